/* source/bus_pkg.sv */
package bus_pkg;

    // Data path
    localparam int WORD_W = 32;                     // Bus data word width

    // Address split, slave field sits above register field
    localparam int REG_ADDR_W = 2;                  // Register select bits inside a slave
    localparam int SLV_ADDR_W = 2;                  // Slave select bits
    localparam int ADDR_W     = SLV_ADDR_W + REG_ADDR_W;  // Full bus address, 4 bits

    // Level of rw
    localparam logic BUS_READ  = 1'b1;              // Read access
    localparam logic BUS_WRITE = 1'b0;              // Write access

    // Slave indices in the slave field
    localparam logic [SLV_ADDR_W-1:0] SLV_GPIO  = 2'd0;   // GPIO block
    localparam logic [SLV_ADDR_W-1:0] SLV_TIMER = 2'd1;   // Interval timer
    // Indices 2 and 3 are left unmapped and answered by the controller

endpackage

/* source/periph_pkg.sv */
package periph_pkg;

    // GPIO register offsets
    localparam logic [bus_pkg::REG_ADDR_W-1:0] GPIO_REG_IN  = 2'd0;  // Input pins, read only
    localparam logic [bus_pkg::REG_ADDR_W-1:0] GPIO_REG_OUT = 2'd1;  // Output register
    localparam logic [bus_pkg::REG_ADDR_W-1:0] GPIO_REG_IO  = 2'd2;  // Bidirectional data
    localparam logic [bus_pkg::REG_ADDR_W-1:0] GPIO_REG_DIR = 2'd3;  // Direction register

    // Direction register bit values
    localparam logic DIR_IN  = 1'b0;                // Pin floats, sampled as input
    localparam logic DIR_OUT = 1'b1;                // Pin driven from io output reg

    // Timer register offsets
    localparam logic [bus_pkg::REG_ADDR_W-1:0] TMR_REG_CTRL   = 2'd0;  // Enable and mode bits
    localparam logic [bus_pkg::REG_ADDR_W-1:0] TMR_REG_FLAG   = 2'd1;  // Expiry flag, write clears
    localparam logic [bus_pkg::REG_ADDR_W-1:0] TMR_REG_PERIOD = 2'd2;  // Terminal count
    localparam logic [bus_pkg::REG_ADDR_W-1:0] TMR_REG_COUNT  = 2'd3;  // Running counter

    // Control word bit positions
    localparam int TMR_CTRL_EN       = 0;           // Counter runs while set
    localparam int TMR_CTRL_PERIODIC = 1;           // Keep enable after expiry

endpackage

/* source/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl import bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  as_n,          // Master strobe, one cycle
    input  logic                  rw,
    input  logic [ADDR_W-1:0]     addr,
    input  logic [WORD_W-1:0]     wr_data,
    input  logic [WORD_W-1:0]     gpio_rd_data,
    input  logic                  gpio_rdy_n,
    input  logic [WORD_W-1:0]     tmr_rd_data,
    input  logic                  tmr_rdy_n,
    output logic                  gpio_cs_n,
    output logic                  tmr_cs_n,
    output logic [REG_ADDR_W-1:0] reg_addr,      // Register field to slaves
    output logic                  slv_rw,
    output logic [WORD_W-1:0]     slv_wr_data,
    output logic [WORD_W-1:0]     rd_data,       // Reply to master
    output logic                  rdy_n,
    output logic                  bus_err        // Valid while rdy_n low
);

    logic [SLV_ADDR_W-1:0] slv_idx;              // Slave field of current address
    logic [SLV_ADDR_W-1:0] slv_q;                // Slave of the access in flight
    logic                  mapped;               // Slave field hits a real slave
    logic                  err_q;                // Unmapped access awaiting reply

    assign slv_idx = addr[ADDR_W-1:REG_ADDR_W];
    assign mapped  = (slv_idx == SLV_GPIO) || (slv_idx == SLV_TIMER);

    // Chip selects qualified by the strobe
    assign gpio_cs_n = !(!as_n && (slv_idx == SLV_GPIO));
    assign tmr_cs_n  = !(!as_n && (slv_idx == SLV_TIMER));

    // Shared request lines to both slaves
    assign reg_addr    = addr[REG_ADDR_W-1:0];
    assign slv_rw      = rw;
    assign slv_wr_data = wr_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            slv_q <= SLV_GPIO;                   // GPIO rdy_n idles high after reset
            err_q <= 1'b0;
        end else begin
            if (!as_n) begin
                slv_q <= slv_idx;                // Remember target for reply cycle
            end
            err_q <= !as_n && !mapped;           // Own reply for unmapped space
        end
    end

    // Reply routing from the remembered slave
    always_comb begin
        case (slv_q)
            SLV_GPIO: begin
                rd_data = gpio_rd_data;
                rdy_n   = gpio_rdy_n;
            end
            SLV_TIMER: begin
                rd_data = tmr_rd_data;
                rdy_n   = tmr_rdy_n;
            end
            default: begin
                rd_data = '0;                    // Unmapped reads give zero
                rdy_n   = !err_q;
            end
        endcase
    end

    assign bus_err = err_q;

    // Decode must never select two slaves at once
    a_cs_onehot: assert property (@(posedge clk) disable iff (rst)
        !(!gpio_cs_n && !tmr_cs_n));

    // Master may not strobe again while the reply is on the bus
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !rdy_n |-> as_n);

endmodule

/* source/gpio.sv */
`timescale 1ns/1ps

module gpio import bus_pkg::*, periph_pkg::*; #(
    parameter int GPIO_IN_CH  = 8,               // Input pin count
    parameter int GPIO_OUT_CH = 8,               // Output pin count
    parameter int GPIO_IO_CH  = 8                // Bidirectional pin count
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cs_n,         // Already qualified by strobe
    input  logic                   rw,
    input  logic [REG_ADDR_W-1:0]  reg_addr,
    input  logic [WORD_W-1:0]      wr_data,
    input  logic [GPIO_IN_CH-1:0]  gpio_in,
    output logic [WORD_W-1:0]      rd_data,
    output logic                   rdy_n,
    output logic [GPIO_OUT_CH-1:0] gpio_out,
    inout  wire  [GPIO_IO_CH-1:0]  gpio_io
);

    logic [GPIO_IO_CH-1:0] io_in;                // Sampled pin levels
    logic [GPIO_IO_CH-1:0] io_out;               // Value driven on output pins
    logic [GPIO_IO_CH-1:0] io_dir;               // Per-pin direction

    // Pin counts must fit in one bus word
    if (GPIO_IN_CH < 1 || GPIO_IN_CH > WORD_W) begin : g_chk_in
        $error("GPIO_IN_CH out of range");
    end
    if (GPIO_OUT_CH < 1 || GPIO_OUT_CH > WORD_W) begin : g_chk_out
        $error("GPIO_OUT_CH out of range");
    end
    if (GPIO_IO_CH < 1 || GPIO_IO_CH > WORD_W) begin : g_chk_io
        $error("GPIO_IO_CH out of range");
    end

    assign io_in = gpio_io;                      // Pin level, own drive included

    // Tri-state buffer per pin
    for (genvar i = 0; i < GPIO_IO_CH; i++) begin : g_io
        assign gpio_io[i] = (io_dir[i] == DIR_OUT) ? io_out[i] : 1'bz;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data  <= '0;
            rdy_n    <= 1'b1;
            gpio_out <= '0;
            io_out   <= '0;
            io_dir   <= {GPIO_IO_CH{DIR_IN}};    // All pins start as inputs
        end else begin
            rdy_n <= cs_n;                       // One-cycle ready after select

            // Read path, zero outside a read reply
            if (!cs_n && rw == BUS_READ) begin
                case (reg_addr)
                    GPIO_REG_IN:  rd_data <= WORD_W'(gpio_in);
                    GPIO_REG_OUT: rd_data <= WORD_W'(gpio_out);
                    GPIO_REG_IO:  rd_data <= WORD_W'(io_in);
                    GPIO_REG_DIR: rd_data <= WORD_W'(io_dir);
                endcase
            end else begin
                rd_data <= '0;
            end

            // Write path, input register ignores writes
            if (!cs_n && rw == BUS_WRITE) begin
                case (reg_addr)
                    GPIO_REG_OUT: gpio_out <= wr_data[GPIO_OUT_CH-1:0];
                    GPIO_REG_IO:  io_out   <= wr_data[GPIO_IO_CH-1:0];
                    GPIO_REG_DIR: io_dir   <= wr_data[GPIO_IO_CH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Ready only ever answers a select in the previous cycle
    a_rdy_after_cs: assert property (@(posedge clk) disable iff (rst)
        !rdy_n |-> $past(!cs_n));

endmodule

/* source/timer.sv */
`timescale 1ns/1ps

module timer import bus_pkg::*, periph_pkg::*; #(
    parameter int TMR_W = 16                     // Counter and period width
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cs_n,          // Already qualified by strobe
    input  logic                  rw,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [WORD_W-1:0]     wr_data,
    output logic [WORD_W-1:0]     rd_data,
    output logic                  rdy_n,
    output logic                  irq            // Follows the expiry flag
);

    logic             ctrl_en;                   // Counter running
    logic             ctrl_per;                  // Periodic mode
    logic             flag;                      // Sticky expiry flag
    logic [TMR_W-1:0] period;                    // Terminal count
    logic [TMR_W-1:0] count;                     // Running count
    logic [WORD_W-1:0] ctrl_word;                // Control register as read

    if (TMR_W < 1 || TMR_W > WORD_W) begin : g_chk_w
        $error("TMR_W out of range");
    end

    always_comb begin
        ctrl_word                    = '0;
        ctrl_word[TMR_CTRL_EN]       = ctrl_en;
        ctrl_word[TMR_CTRL_PERIODIC] = ctrl_per;
    end

    assign irq = flag;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data  <= '0;
            rdy_n    <= 1'b1;
            ctrl_en  <= 1'b0;
            ctrl_per <= 1'b0;
            flag     <= 1'b0;
            period   <= '0;
            count    <= '0;
        end else begin
            rdy_n <= cs_n;                       // One-cycle ready after select

            if (!cs_n && rw == BUS_READ) begin
                case (reg_addr)
                    TMR_REG_CTRL:   rd_data <= ctrl_word;
                    TMR_REG_FLAG:   rd_data <= WORD_W'(flag);
                    TMR_REG_PERIOD: rd_data <= WORD_W'(period);
                    TMR_REG_COUNT:  rd_data <= WORD_W'(count);
                endcase
            end else begin
                rd_data <= '0;
            end

            // Counting, overridden below by a bus write
            if (ctrl_en) begin
                if (count == period) begin
                    count <= '0;                 // Expiry wraps to zero
                    flag  <= 1'b1;
                    if (!ctrl_per) begin
                        ctrl_en <= 1'b0;         // One-shot stops here
                    end
                end else begin
                    count <= count + TMR_W'(1);
                end
            end

            if (!cs_n && rw == BUS_WRITE) begin
                case (reg_addr)
                    TMR_REG_CTRL: begin
                        ctrl_en  <= wr_data[TMR_CTRL_EN];
                        ctrl_per <= wr_data[TMR_CTRL_PERIODIC];
                    end
                    TMR_REG_FLAG:   flag   <= 1'b0;  // Any value clears
                    TMR_REG_PERIOD: period <= wr_data[TMR_W-1:0];
                    TMR_REG_COUNT:  count  <= wr_data[TMR_W-1:0];
                endcase
            end
        end
    end

    // Count past the period would run through the full range before expiry
    a_count_le_period: assert property (@(posedge clk) disable iff (rst)
        ctrl_en |-> (count <= period));

endmodule

/* source/periph_top.sv */
`timescale 1ns/1ps

module periph_top import bus_pkg::*; #(
    parameter int GPIO_IN_CH  = 8,
    parameter int GPIO_OUT_CH = 8,
    parameter int GPIO_IO_CH  = 8,
    parameter int TMR_W       = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   as_n,
    input  logic                   rw,
    input  logic [ADDR_W-1:0]      addr,
    input  logic [WORD_W-1:0]      wr_data,
    output logic [WORD_W-1:0]      rd_data,
    output logic                   rdy_n,
    output logic                   bus_err,
    input  logic [GPIO_IN_CH-1:0]  gpio_in,
    output logic [GPIO_OUT_CH-1:0] gpio_out,
    inout  wire  [GPIO_IO_CH-1:0]  gpio_io,
    output logic                   tmr_irq
);

    logic                  gpio_cs_n;            // Controller to GPIO select
    logic                  tmr_cs_n;             // Controller to timer select
    logic [REG_ADDR_W-1:0] reg_addr;
    logic                  slv_rw;
    logic [WORD_W-1:0]     slv_wr_data;
    logic [WORD_W-1:0]     gpio_rd_data;
    logic                  gpio_rdy_n;
    logic [WORD_W-1:0]     tmr_rd_data;
    logic                  tmr_rdy_n;

    bus_ctrl bus_ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .as_n         (as_n),
        .rw           (rw),
        .addr         (addr),
        .wr_data      (wr_data),
        .gpio_rd_data (gpio_rd_data),
        .gpio_rdy_n   (gpio_rdy_n),
        .tmr_rd_data  (tmr_rd_data),
        .tmr_rdy_n    (tmr_rdy_n),
        .gpio_cs_n    (gpio_cs_n),
        .tmr_cs_n     (tmr_cs_n),
        .reg_addr     (reg_addr),
        .slv_rw       (slv_rw),
        .slv_wr_data  (slv_wr_data),
        .rd_data      (rd_data),
        .rdy_n        (rdy_n),
        .bus_err      (bus_err)
    );

    gpio #(
        .GPIO_IN_CH  (GPIO_IN_CH),
        .GPIO_OUT_CH (GPIO_OUT_CH),
        .GPIO_IO_CH  (GPIO_IO_CH)
    ) gpio0 (
        .clk      (clk),
        .rst      (rst),
        .cs_n     (gpio_cs_n),
        .rw       (slv_rw),
        .reg_addr (reg_addr),
        .wr_data  (slv_wr_data),
        .gpio_in  (gpio_in),
        .rd_data  (gpio_rd_data),
        .rdy_n    (gpio_rdy_n),
        .gpio_out (gpio_out),
        .gpio_io  (gpio_io)
    );

    timer #(
        .TMR_W (TMR_W)
    ) timer0 (
        .clk      (clk),
        .rst      (rst),
        .cs_n     (tmr_cs_n),
        .rw       (slv_rw),
        .reg_addr (reg_addr),
        .wr_data  (slv_wr_data),
        .rd_data  (tmr_rd_data),
        .rdy_n    (tmr_rdy_n),
        .irq      (tmr_irq)
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0                // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;        // Half period per phase
        end
    end

endmodule

/* verification/periph_tb.sv */
`timescale 1ns/1ps

module periph_tb import bus_pkg::*, periph_pkg::*; ();

    localparam int IN_CH       = 8;               // Must match dut0 parameters
    localparam int OUT_CH      = 8;
    localparam int IO_CH       = 8;
    localparam int TMR_W       = 16;
    localparam int RDY_TIMEOUT = 20;              // Cycles allowed for rdy_n
    localparam logic [WORD_W-1:0] RAND_MARK = 32'hffff_ffff;  // Pattern marker for random data

    logic                 clk;
    logic                 rst;
    logic                 as_n;
    logic                 rw;
    logic [ADDR_W-1:0]    addr;
    logic [WORD_W-1:0]    wr_data;
    logic [WORD_W-1:0]    rd_data;
    logic                 rdy_n;
    logic                 bus_err;
    logic                 tmr_irq;
    logic [IN_CH-1:0]     gpio_in;
    logic [OUT_CH-1:0]    gpio_out;
    wire  [IO_CH-1:0]     gpio_io;
    logic [IO_CH-1:0]     io_drv;                 // External value on bidir pins
    logic [IO_CH-1:0]     io_drv_en;              // Per-pin external driver enable
    logic [WORD_W-1:0]    last_rand;              // Last random write word
    integer               seed;
    int                   errors;
    int                   test_errs;              // Errors of the running test
    int                   tests_run;
    int                   tests_bad;
    logic                 aborted;                // Timeout or file problem

    tb_clock #(.PERIOD_NS(4.0)) clock0 (.clk(clk));

    periph_top #(
        .GPIO_IN_CH  (IN_CH),
        .GPIO_OUT_CH (OUT_CH),
        .GPIO_IO_CH  (IO_CH),
        .TMR_W       (TMR_W)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .as_n     (as_n),
        .rw       (rw),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rdy_n    (rdy_n),
        .bus_err  (bus_err),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_io  (gpio_io),
        .tmr_irq  (tmr_irq)
    );

    assign (weak0, weak1) gpio_io = '0;           // Pull-down for released pins

    for (genvar i = 0; i < IO_CH; i++) begin : g_drv
        assign gpio_io[i] = io_drv_en[i] ? io_drv[i] : 1'bz;
    end

    // Register width seen on read-back
    function automatic logic [WORD_W-1:0] reg_mask(input logic [ADDR_W-1:0] a);
        case (a)
            {SLV_GPIO, GPIO_REG_IN}:    return WORD_W'((64'd1 << IN_CH) - 64'd1);
            {SLV_GPIO, GPIO_REG_OUT}:   return WORD_W'((64'd1 << OUT_CH) - 64'd1);
            {SLV_GPIO, GPIO_REG_IO},
            {SLV_GPIO, GPIO_REG_DIR}:   return WORD_W'((64'd1 << IO_CH) - 64'd1);
            {SLV_TIMER, TMR_REG_CTRL}:  return 32'h3;
            {SLV_TIMER, TMR_REG_FLAG}:  return 32'h1;
            {SLV_TIMER, TMR_REG_PERIOD},
            {SLV_TIMER, TMR_REG_COUNT}: return WORD_W'((64'd1 << TMR_W) - 64'd1);
            default:                    return '0;
        endcase
    endfunction

    // DUT-driven pin level behind a register with a valid flag on top
    function automatic logic [WORD_W:0] pin_view(input logic [ADDR_W-1:0] a);
        case (a)
            {SLV_GPIO, GPIO_REG_OUT}:  return {1'b1, WORD_W'(gpio_out)};
            {SLV_GPIO, GPIO_REG_IO},
            {SLV_GPIO, GPIO_REG_DIR}:  return {1'b1, WORD_W'(gpio_io)};
            {SLV_TIMER, TMR_REG_FLAG}: return {1'b1, WORD_W'(tmr_irq)};
            default:                   return '0;
        endcase
    endfunction

    function automatic string view_name(input logic [ADDR_W-1:0] a);
        case (a)
            {SLV_GPIO, GPIO_REG_OUT}:  return "gpio_out";
            {SLV_TIMER, TMR_REG_FLAG}: return "tmr_irq";
            default:                   return "gpio_io";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] got);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic fail_note(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        test_errs++;
    endtask

    task automatic close_test(input int num);
        if (test_errs == 0) begin
            $display("test %0d ok", num);
        end else begin
            $display("test %0d failed with %0d errors", num, test_errs);
            tests_bad++;
        end
        tests_run++;
        errors += test_errs;
        test_errs = 0;
    endtask

    // One strobed access with the reply sampled on the falling edge
    task automatic bus_access(input logic is_rd, input logic [ADDR_W-1:0] a,
                              input logic [WORD_W-1:0] d, output logic [WORD_W-1:0] rdat,
                              output logic err, output logic [WORD_W:0] view,
                              output int lat, output logic ok, output logic pulse_ok);
        @(posedge clk);
        as_n    <= 1'b0;
        rw      <= is_rd ? BUS_READ : BUS_WRITE;
        addr    <= a;
        wr_data <= d;
        if (!is_rd && a == {SLV_GPIO, GPIO_REG_DIR}) begin
            io_drv_en <= ~d[IO_CH-1:0];           // Release pins turning to output
        end
        @(posedge clk);
        as_n    <= 1'b1;                          // Strobe lasts one cycle
        wr_data <= '0;
        lat      = 0;
        ok       = 1'b0;
        pulse_ok = 1'b0;
        rdat     = '0;
        err      = 1'b0;
        view     = '0;
        while (!ok && lat < RDY_TIMEOUT) begin
            @(negedge clk);
            if (rdy_n === 1'b0) begin
                ok   = 1'b1;
                rdat = rd_data;
                err  = bus_err;
                view = pin_view(a);
            end else begin
                lat++;
            end
        end
        if (ok) begin
            @(negedge clk);
            pulse_ok = (rdy_n === 1'b1);          // Ready is a single-cycle pulse
        end
    endtask

    initial begin : main
        int                  fd;
        int                  n;
        int                  cnt;
        int                  cur_test;
        int                  t_in;
        int                  lat;
        int                  waited;
        logic [8*160-1:0]    line_buf;
        logic [8*8-1:0]      op_tok;
        logic [WORD_W-1:0]   a_in;
        logic [WORD_W-1:0]   d_in;
        logic [WORD_W-1:0]   e_in;
        logic [WORD_W-1:0]   exp_v;
        logic [WORD_W-1:0]   got_d;
        logic [WORD_W:0]     view;
        logic                got_err;
        logic                exp_err;
        logic                is_rd;
        logic                ok;
        logic                pulse_ok;

        rst       = 1'b1;
        as_n      = 1'b1;
        rw        = BUS_READ;
        addr      = '0;
        wr_data   = '0;
        gpio_in   = '0;
        io_drv    = '0;
        io_drv_en = '1;                           // Pins start driven from outside
        last_rand = '0;
        seed      = 32'h0fbf_346d;
        errors    = 0;
        test_errs = 0;
        tests_run = 0;
        tests_bad = 0;
        aborted   = 1'b0;
        cur_test  = -1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("verification/periph_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verification/periph_patterns.txt");
            errors++;
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            line_buf = '0;
            op_tok   = '0;
            n   = $fgets(line_buf, fd);
            cnt = (n == 0) ? 0 : $sscanf(line_buf, "%s %h %h %h %d",
                                         op_tok, a_in, d_in, e_in, t_in);
            if (cnt <= 0 || op_tok == "#") begin
                continue;                         // Blank or comment line
            end
            if (cnt != 5) begin
                fail_note("malformed line in the pattern file");
                continue;
            end
            if (t_in != cur_test) begin
                if (cur_test >= 0) begin
                    close_test(cur_test);
                end
                cur_test = t_in;
            end

            if (op_tok == "read" || op_tok == "write") begin
                is_rd = (op_tok == "read");
                if (!is_rd && d_in == RAND_MARK) begin
                    last_rand = $random(seed);
                    d_in      = last_rand;
                end
                exp_v   = (e_in == RAND_MARK) ? (last_rand & reg_mask(a_in[ADDR_W-1:0])) : e_in;
                exp_err = (a_in[ADDR_W-1:REG_ADDR_W] >= 2'd2);  // Indices 2 and 3 have no slave
                bus_access(is_rd, a_in[ADDR_W-1:0], d_in, got_d, got_err, view,
                           lat, ok, pulse_ok);
                if (!ok) begin
                    fail_note("no rdy_n within 20 cycles of the strobe");
                    aborted = 1'b1;
                end else begin
                    if (lat != 0) begin
                        fail_note($sformatf("rdy_n came %0d cycles late", lat));
                    end
                    if (!pulse_ok) begin
                        fail_note("rdy_n stayed low for more than one cycle");
                    end
                    check_value("bus_err", WORD_W'(exp_err), WORD_W'(got_err));
                    check_value("rd_data", is_rd ? exp_v : '0, got_d);
                    if (!is_rd && view[WORD_W]) begin
                        check_value(view_name(a_in[ADDR_W-1:0]), exp_v, view[WORD_W-1:0]);
                    end
                end
            end else if (op_tok == "pin") begin
                @(posedge clk);
                if (a_in[ADDR_W-1:0] == {SLV_GPIO, GPIO_REG_IN}) begin
                    gpio_in <= d_in[IN_CH-1:0];
                end else begin
                    io_drv <= d_in[IO_CH-1:0];
                end
                @(negedge clk);
                view = pin_view(a_in[ADDR_W-1:0]);
                if (view[WORD_W]) begin
                    check_value(view_name(a_in[ADDR_W-1:0]), e_in, view[WORD_W-1:0]);
                end
            end else if (op_tok == "irq") begin
                waited = 0;
                while (tmr_irq !== 1'b1 && waited < d_in + 20) begin
                    @(negedge clk);
                    waited++;
                end
                if (tmr_irq !== 1'b1) begin
                    fail_note("tmr_irq did not rise within period plus 20 cycles");
                    aborted = 1'b1;
                end
            end else begin
                fail_note("unknown operation in the pattern file");
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        if (cur_test >= 0) begin
            close_test(cur_test);
        end else begin
            errors += test_errs;                  // Faults seen before any test number
        end
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/periph_patterns.txt */
# op addr(hex) data(hex) expect(hex) test(dec); ops read write pin irq
# data ffffffff on a write draws a random word, expect ffffffff means that word masked
pin   0 0000005a 0000005a 1
read  0 00000000 0000005a 1
read  1 00000000 00000000 1
read  2 00000000 00000000 1
read  3 00000000 00000000 1
read  4 00000000 00000000 1
read  5 00000000 00000000 1
read  6 00000000 00000000 1
read  7 00000000 00000000 1
write 1 000001c3 000000c3 2
read  1 00000000 000000c3 2
write 1 ffffffff ffffffff 2
read  1 00000000 ffffffff 2
pin   2 0000003c 0000003c 3
read  2 00000000 0000003c 3
write 2 000000a5 0000003c 3
write 3 0000000f 00000035 3
read  2 00000000 00000035 3
read  3 00000000 0000000f 3
pin   0 00000081 00000081 3
read  0 00000000 00000081 3
write 6 ffffffff ffffffff 4
read  6 00000000 ffffffff 4
write 7 00000002 00000000 4
read  7 00000000 00000002 4
write 6 00000005 00000000 4
write 4 00000001 00000000 4
irq   0 00000005 00000000 4
read  4 00000000 00000000 4
read  5 00000000 00000001 4
write 5 00000000 00000000 4
read  5 00000000 00000000 4
write 4 00000003 00000000 5
irq   0 00000005 00000000 5
write 5 00000000 00000000 5
irq   0 00000005 00000000 5
read  4 00000000 00000003 5
write 4 00000000 00000000 5
write 5 00000000 00000000 5
read  8 00000000 00000000 6
write c 12345678 00000000 6
read  f 00000000 00000000 6
read  0 00000000 00000081 6

/* sim.f */
source/bus_pkg.sv
source/periph_pkg.sv
source/bus_ctrl.sv
source/gpio.sv
source/timer.sv
source/periph_top.sv
verification/tb_clock.sv
verification/periph_tb.sv

/* Bender.yml */
package:
  name: periph

sources:
  - source/bus_pkg.sv
  - source/periph_pkg.sv
  - source/bus_ctrl.sv
  - source/gpio.sv
  - source/timer.sv
  - source/periph_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/periph_tb.sv
